// ==== hdl/alu_regs_pkg.sv ====
// only whole 32-bit words are decoded; address bits 4:2 pick the word and bits 1:0 are ignored.
package alu_regs_pkg;

    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 32;
    localparam int REG_STRB_WIDTH = REG_DATA_WIDTH / 8;
    localparam int REG_NUM        = 5;
    localparam int REG_IDX_LSB    = 2;  // byte offset bits are below this.
    localparam int REG_IDX_MSB    = 4;
    localparam int SHIFT_WIDTH    = 5;  // shift amount is taken from the low bits of operand b.

    localparam int REG_CTRL   = 0;  // byte address 0x00.
    localparam int REG_OPA    = 1;  // byte address 0x04.
    localparam int REG_OPB    = 2;  // byte address 0x08.
    localparam int REG_RESULT = 3;  // byte address 0x0c.
    localparam int REG_STATUS = 4;  // byte address 0x10.

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef logic [REG_NUM-1:0][REG_DATA_WIDTH-1:0] reg_t;

    // codes 7 to 15 are invalid and complete with the error flag set.
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SHL = 4'd5,
        OP_SHR = 4'd6
    } alu_op_e;

    typedef struct packed {
        logic [22:0] reserved_hi;
        logic        start;
        logic [3:0]  reserved_lo;
        alu_op_e     opcode;
    } ctrl_reg_t;

    typedef struct packed {
        alu_op_e                   opcode;
        logic [REG_DATA_WIDTH-1:0] operand_a;
        logic [REG_DATA_WIDTH-1:0] operand_b;
    } alu_cmd_t;

    typedef struct packed {
        logic [REG_DATA_WIDTH-1:0] result;
        alu_op_e                   opcode;
        logic                      error;
    } alu_rsp_t;

    typedef struct packed {
        logic [6:0]  reserved_hi;
        logic        error;
        logic [3:0]  reserved_lo;
        alu_op_e     last_opcode;
        logic [15:0] op_count;
    } status_reg_t;

endpackage

// ==== hdl/axil_if.sv ====
// AXI-Lite without prot signals; the slave always answers OKAY and data is one 32-bit word.
`timescale 1ns/10ps

interface axil_if import alu_regs_pkg::*; (
    input logic clk_i,
    input logic rstn_i
);

    logic [REG_ADDR_WIDTH-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;

    logic [REG_DATA_WIDTH-1:0] wdata;
    logic [REG_STRB_WIDTH-1:0] wstrb;
    logic                      wvalid;
    logic                      wready;

    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;

    logic [REG_ADDR_WIDTH-1:0] araddr;
    logic                      arvalid;
    logic                      arready;

    logic [REG_DATA_WIDTH-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    modport master (
        input  clk_i, rstn_i,
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  clk_i, rstn_i,
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

// ==== hdl/axil_reg_file.sv ====
// the host waits for B before a new write and for R before a new read; unmapped words read zero.
`timescale 1ns/10ps

module axil_reg_file import alu_regs_pkg::*; #(
    parameter reg_t REG_INIT = '0
) (
    axil_if.slave              s_axil,

    input  reg_t               rd_regs_i,
    input  logic [REG_NUM-1:0] rd_valid_i,

    output reg_t               wr_regs_o,
    output logic [REG_NUM-1:0] wr_valid_o
);

    logic                           clk_i;
    logic                           rstn_i;

    reg_t                           wr_image;
    reg_t                           rd_image;
    reg_t                           rd_regs_q;
    logic [REG_NUM-1:0]             rd_valid_q;
    logic [REG_NUM-1:0]             wr_valid_q;

    logic [REG_IDX_MSB:REG_IDX_LSB] aw_idx_q;
    logic [REG_IDX_MSB:REG_IDX_LSB] ar_idx_q;

    logic                           write_valid;
    logic                           wr_handshake;
    logic                           ar_handshake;

    assign clk_i  = s_axil.clk_i;
    assign rstn_i = s_axil.rstn_i;

    assign write_valid  = s_axil.awvalid & s_axil.wvalid;
    assign wr_handshake = write_valid & s_axil.awready & s_axil.wready;
    assign ar_handshake = s_axil.arvalid & s_axil.arready;

    assign s_axil.bresp = AXI_RESP_OKAY;
    assign s_axil.rresp = AXI_RESP_OKAY;

    // boundary registers towards the core and from the collector.
    always_ff @(posedge clk_i) begin
        wr_regs_o <= wr_image;
        rd_regs_q <= rd_regs_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_valid_o <= '0;
            rd_valid_q <= '0;
        end else begin
            wr_valid_o <= wr_valid_q;
            rd_valid_q <= rd_valid_i;
        end
    end

    // byte lanes are merged under wstrb. The flag for the word is a one-cycle pulse.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_image   <= REG_INIT;
            wr_valid_q <= '0;
        end else begin
            wr_valid_q <= '0;
            if (wr_handshake) begin
                for (int idx = 0; idx < REG_NUM; idx++) begin
                    if (int'(aw_idx_q) == idx) begin
                        for (int b = 0; b < REG_STRB_WIDTH; b++) begin
                            if (s_axil.wstrb[b]) begin
                                wr_image[idx][b*8 +: 8] <= s_axil.wdata[b*8 +: 8];
                            end
                        end
                        wr_valid_q[idx] <= 1'b1;
                    end
                end
            end
        end
    end

    // awready and wready pulse together once both channels are valid.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_axil.awready <= 1'b0;
            s_axil.wready  <= 1'b0;
        end else begin
            if (write_valid && !s_axil.awready && !s_axil.bvalid) begin
                s_axil.awready <= 1'b1;
                s_axil.wready  <= 1'b1;
            end else begin
                s_axil.awready <= 1'b0;
                s_axil.wready  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_valid && !s_axil.awready) begin
            aw_idx_q <= s_axil.awaddr[REG_IDX_MSB:REG_IDX_LSB];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_axil.bvalid <= 1'b0;
        end else if (wr_handshake) begin
            s_axil.bvalid <= 1'b1;
        end else if (s_axil.bvalid && s_axil.bready) begin
            s_axil.bvalid <= 1'b0;
        end
    end

    // the read image only takes words the collector flags.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rd_image <= REG_INIT;
        end else begin
            for (int idx = 0; idx < REG_NUM; idx++) begin
                if (rd_valid_q[idx]) begin
                    rd_image[idx] <= rd_regs_q[idx];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_axil.arready <= 1'b0;
        end else begin
            s_axil.arready <= s_axil.arvalid && !s_axil.arready && !s_axil.rvalid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_axil.arvalid && !s_axil.arready) begin
            ar_idx_q <= s_axil.araddr[REG_IDX_MSB:REG_IDX_LSB];
        end
    end

    // rdata is loaded only on the handshake, so it stays put while rvalid waits.
    always_ff @(posedge clk_i) begin
        if (ar_handshake) begin
            s_axil.rdata <= '0;
            for (int idx = 0; idx < REG_NUM; idx++) begin
                if (int'(ar_idx_q) == idx) begin
                    s_axil.rdata <= rd_image[idx];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_axil.rvalid <= 1'b0;
        end else if (ar_handshake) begin
            s_axil.rvalid <= 1'b1;
        end else if (s_axil.rvalid && s_axil.rready) begin
            s_axil.rvalid <= 1'b0;
        end
    end

endmodule

// ==== hdl/alu_core.sv ====
// no back-pressure; each start write yields one response two cycles after its write pulse.
`timescale 1ns/10ps

module alu_core import alu_regs_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  reg_t               wr_regs_i,
    input  logic [REG_NUM-1:0] wr_valid_i,

    output logic               rsp_valid_o,
    output alu_rsp_t           rsp_o
);

    ctrl_reg_t ctrl;
    logic      issue;
    alu_cmd_t  cmd_q;
    logic      cmd_valid_q;
    alu_rsp_t  rsp_d;

    assign ctrl  = ctrl_reg_t'(wr_regs_i[REG_CTRL]);
    assign issue = wr_valid_i[REG_CTRL] & ctrl.start;

    // stage one captures the opcode with the operand words as they stand.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= issue;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            cmd_q.opcode    <= ctrl.opcode;
            cmd_q.operand_a <= wr_regs_i[REG_OPA];
            cmd_q.operand_b <= wr_regs_i[REG_OPB];
        end
    end

    always_comb begin
        rsp_d.opcode = cmd_q.opcode;
        rsp_d.error  = 1'b0;
        case (cmd_q.opcode)
            OP_ADD: rsp_d.result = cmd_q.operand_a + cmd_q.operand_b;
            OP_SUB: rsp_d.result = cmd_q.operand_a - cmd_q.operand_b;  // wraps modulo 2^32.
            OP_AND: rsp_d.result = cmd_q.operand_a & cmd_q.operand_b;
            OP_OR:  rsp_d.result = cmd_q.operand_a | cmd_q.operand_b;
            OP_XOR: rsp_d.result = cmd_q.operand_a ^ cmd_q.operand_b;
            OP_SHL: rsp_d.result = cmd_q.operand_a << cmd_q.operand_b[SHIFT_WIDTH-1:0];
            OP_SHR: rsp_d.result = cmd_q.operand_a >> cmd_q.operand_b[SHIFT_WIDTH-1:0];
            default: begin
                rsp_d.result = '0;
                rsp_d.error  = 1'b1;
            end
        endcase
    end

    // stage two registers the response.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= cmd_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_q) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

// ==== hdl/result_collector.sv ====
// result and status are read-only; host writes to them never reach the read image.
`timescale 1ns/10ps

module result_collector import alu_regs_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  reg_t               wr_regs_i,
    input  logic [REG_NUM-1:0] wr_valid_i,
    input  logic               rsp_valid_i,
    input  alu_rsp_t           rsp_i,

    output reg_t               rd_regs_o,
    output logic [REG_NUM-1:0] rd_valid_o
);

    logic [REG_NUM-1:0] mirror_valid;
    logic [REG_NUM-1:0] rsp_mask;
    logic [15:0]        op_count_q;
    status_reg_t        status_d;

    always_comb begin
        mirror_valid             = wr_valid_i;
        mirror_valid[REG_RESULT] = 1'b0;
        mirror_valid[REG_STATUS] = 1'b0;
        rsp_mask                 = '0;
        rsp_mask[REG_RESULT]     = rsp_valid_i;
        rsp_mask[REG_STATUS]     = rsp_valid_i;
    end

    always_comb begin
        status_d             = '0;
        status_d.op_count    = op_count_q + 16'd1;  // wraps at 16 bits.
        status_d.last_opcode = rsp_i.opcode;
        status_d.error       = rsp_i.error;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            op_count_q <= '0;
            rd_valid_o <= '0;
        end else begin
            if (rsp_valid_i) op_count_q <= status_d.op_count;
            rd_valid_o <= mirror_valid | rsp_mask;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int idx = 0; idx < REG_NUM; idx++) begin
            if (mirror_valid[idx]) rd_regs_o[idx] <= wr_regs_i[idx];
        end
        if (rsp_valid_i) begin
            rd_regs_o[REG_RESULT] <= rsp_i.result;
            rd_regs_o[REG_STATUS] <= status_d;
        end
    end

endmodule

// ==== hdl/alu_periph_top.sv ====
// clk_i and rstn_i must be the same clock and reset that feed the bus interface instance.
`timescale 1ns/10ps

module alu_periph_top import alu_regs_pkg::*; (
    input logic   clk_i,
    input logic   rstn_i,
    axil_if.slave s_axil
);

    reg_t               wr_regs;
    logic [REG_NUM-1:0] wr_valid;
    reg_t               rd_regs;
    logic [REG_NUM-1:0] rd_valid;
    logic               rsp_valid;
    alu_rsp_t           rsp;

    axil_reg_file #(
        .REG_INIT(reg_t'('0))  // all words read zero after reset.
    ) axil_reg_file_inst (
        .s_axil    (s_axil),
        .rd_regs_i (rd_regs),
        .rd_valid_i(rd_valid),
        .wr_regs_o (wr_regs),
        .wr_valid_o(wr_valid)
    );

    alu_core alu_core_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_regs_i  (wr_regs),
        .wr_valid_i (wr_valid),
        .rsp_valid_o(rsp_valid),
        .rsp_o      (rsp)
    );

    result_collector result_collector_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_regs_i  (wr_regs),
        .wr_valid_i (wr_valid),
        .rsp_valid_i(rsp_valid),
        .rsp_i      (rsp),
        .rd_regs_o  (rd_regs),
        .rd_valid_o (rd_valid)
    );

endmodule

// ==== verification/tb_alu_periph.sv ====
// assumes a zero reset image and one outstanding bus access at a time; a watchdog bounds the run.
`timescale 1ns/10ps

module tb_alu_periph import alu_regs_pkg::*; ();

    typedef struct packed {
        logic [3:0]                opcode;
        logic [REG_DATA_WIDTH-1:0] a;
        logic [REG_DATA_WIDTH-1:0] b;
        logic                      start;
    } vector_t;

    localparam logic [31:0] LFSR_SEED = 32'hdc25_64c5;
    localparam int NUM_VECTORS     = 12;
    localparam int POLL_LIMIT      = 16;
    localparam int ENTRY_CYCLES    = 300;  // three writes and a full run of polls with delays.
    localparam int MARGIN_CYCLES   = 1000;
    localparam int WATCHDOG_CYCLES = 2 * NUM_VECTORS * ENTRY_CYCLES + MARGIN_CYCLES;

    localparam vector_t VECTORS [NUM_VECTORS] = '{
        '{OP_ADD, 32'hffff_fff0, 32'h0000_0025, 1'b1},  // carry out of bit 31 is lost.
        '{OP_SUB, 32'h0000_0001, 32'h0000_0002, 1'b1},
        '{OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 1'b1},
        '{OP_OR,  32'h1200_0034, 32'h0045_6700, 1'b1},
        '{OP_XOR, 32'ha5a5_a5a5, 32'hffff_0000, 1'b1},
        '{OP_SHL, 32'h0000_0001, 32'h0000_0023, 1'b1},  // only the low 5 bits shift.
        '{OP_SHR, 32'h8000_0000, 32'h0000_001f, 1'b1},
        '{4'd7,   32'h0000_1111, 32'h0000_2222, 1'b1},
        '{OP_ADD, 32'h0000_0005, 32'h0000_0006, 1'b0},
        '{4'd15,  32'hdead_beef, 32'h0000_0001, 1'b1},
        '{OP_SHL, 32'h1234_5678, 32'hffff_ffe4, 1'b1},
        '{OP_SUB, 32'h0000_0000, 32'h0000_1000, 1'b1}
    };

    logic                      clk;
    logic                      rstn;
    logic [31:0]               lfsr_state;
    logic                      random_delays;
    status_reg_t               exp_status;
    logic [REG_DATA_WIDTH-1:0] exp_result;

    axil_if axil_bus (.clk_i(clk), .rstn_i(rstn));

    alu_periph_top alu_periph_top_inst (
        .clk_i (clk),
        .rstn_i(rstn),
        .s_axil(axil_bus)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // taps 32, 22, 2, 1.
    endfunction

    function automatic int random_bits(input int nbits);
        int value;
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic alu_rsp_t model_rsp(input logic [3:0] code,
                                           input logic [REG_DATA_WIDTH-1:0] a,
                                           input logic [REG_DATA_WIDTH-1:0] b);
        alu_rsp_t rsp;
        rsp.opcode = alu_op_e'(code);
        rsp.error  = 1'b0;
        case (code)
            OP_ADD: rsp.result = a + b;
            OP_SUB: rsp.result = a - b;
            OP_AND: rsp.result = a & b;
            OP_OR:  rsp.result = a | b;
            OP_XOR: rsp.result = a ^ b;
            OP_SHL: rsp.result = a << b[4:0];
            OP_SHR: rsp.result = a >> b[4:0];
            default: begin
                rsp.result = '0;
                rsp.error  = 1'b1;
            end
        endcase
        return rsp;
    endfunction

    task automatic fail_and_stop(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input int idx, input logic [REG_DATA_WIDTH-1:0] expected,
                              input logic [REG_DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            fail_and_stop($sformatf("Mismatch at %0t: word %0d read 0x%08h, expected 0x%08h",
                                    $time, idx, actual, expected));
        end
    endtask

    task automatic check_status(input status_reg_t expected, input status_reg_t actual);
        if (actual !== expected) begin
            fail_and_stop($sformatf(
                "Mismatch at %0t: status count %0d op %0d err %b, expected %0d op %0d err %b",
                $time, actual.op_count, actual.last_opcode, actual.error,
                expected.op_count, expected.last_opcode, expected.error));
        end
    endtask

    task automatic check_resp(input logic [1:0] actual);
        if (actual !== AXI_RESP_OKAY) begin
            fail_and_stop($sformatf("Mismatch at %0t: bus response %b, expected OKAY",
                                    $time, actual));
        end
    endtask

    task automatic write_word(input int idx, input logic [REG_DATA_WIDTH-1:0] data,
                              input logic [REG_STRB_WIDTH-1:0] strb);
        int         delay;
        logic [1:0] resp;
        delay = random_delays ? random_bits(3) : 0;
        @(posedge clk);
        axil_bus.awaddr  <= REG_ADDR_WIDTH'(idx * 4);
        axil_bus.awvalid <= 1'b1;
        axil_bus.wdata   <= data;
        axil_bus.wstrb   <= strb;
        axil_bus.wvalid  <= 1'b1;
        axil_bus.bready  <= (delay == 0);
        do @(posedge clk); while (!(axil_bus.awready && axil_bus.wready));
        axil_bus.awvalid <= 1'b0;
        axil_bus.wvalid  <= 1'b0;
        do @(posedge clk); while (!axil_bus.bvalid);
        resp = axil_bus.bresp;
        for (int i = 0; i < delay; i++) begin
            if (i == delay - 1) axil_bus.bready <= 1'b1;
            @(posedge clk);
            if (!axil_bus.bvalid || axil_bus.bresp !== resp) begin
                fail_and_stop("write response dropped or changed before bready was given");
            end
        end
        axil_bus.bready <= 1'b0;
        check_resp(resp);
    endtask

    task automatic read_word(input int idx, output logic [REG_DATA_WIDTH-1:0] data);
        int         delay;
        logic [1:0] resp;
        delay = random_delays ? random_bits(3) : 0;
        @(posedge clk);
        axil_bus.araddr  <= REG_ADDR_WIDTH'(idx * 4);
        axil_bus.arvalid <= 1'b1;
        axil_bus.rready  <= (delay == 0);
        do @(posedge clk); while (!axil_bus.arready);
        axil_bus.arvalid <= 1'b0;
        do @(posedge clk); while (!axil_bus.rvalid);
        data = axil_bus.rdata;
        resp = axil_bus.rresp;
        for (int i = 0; i < delay; i++) begin
            if (i == delay - 1) axil_bus.rready <= 1'b1;
            @(posedge clk);
            if (!axil_bus.rvalid || axil_bus.rdata !== data) begin
                fail_and_stop("read data dropped or changed while waiting for rready");
            end
        end
        axil_bus.rready <= 1'b0;
        check_resp(resp);
    endtask

    // the read image trails the written one by a few cycles.
    task automatic wait_word(input int idx, input logic [REG_DATA_WIDTH-1:0] expected,
                             output logic [REG_DATA_WIDTH-1:0] actual);
        for (int n = 0; n < POLL_LIMIT; n++) begin
            read_word(idx, actual);
            if (actual === expected) break;
        end
    endtask

    task automatic wait_op_count(input logic [15:0] count, output status_reg_t actual);
        logic [REG_DATA_WIDTH-1:0] word;
        for (int n = 0; n < POLL_LIMIT; n++) begin
            read_word(REG_STATUS, word);
            actual = status_reg_t'(word);
            if (actual.op_count === count) break;
        end
    endtask

    task automatic run_vector(input vector_t v);
        ctrl_reg_t                 ctrl;
        alu_rsp_t                  exp_rsp;
        status_reg_t               status;
        logic [REG_DATA_WIDTH-1:0] word;
        ctrl        = '0;
        ctrl.opcode = alu_op_e'(v.opcode);
        ctrl.start  = v.start;
        write_word(REG_OPA, v.a, '1);
        write_word(REG_OPB, v.b, '1);
        write_word(REG_CTRL, ctrl, '1);
        if (v.start) begin
            exp_rsp                = model_rsp(v.opcode, v.a, v.b);
            exp_status.op_count    = exp_status.op_count + 16'd1;
            exp_status.last_opcode = exp_rsp.opcode;
            exp_status.error       = exp_rsp.error;
            exp_result             = exp_rsp.result;
            wait_op_count(exp_status.op_count, status);
        end else begin
            // the control mirror lands before any response would.
            wait_word(REG_CTRL, ctrl, word);
            check_word(REG_CTRL, ctrl, word);
            read_word(REG_STATUS, word);
            status = status_reg_t'(word);
        end
        check_status(exp_status, status);
        read_word(REG_RESULT, word);
        check_word(REG_RESULT, exp_result, word);
    endtask

    initial begin
        logic [REG_DATA_WIDTH-1:0] word;
        rstn             <= 1'b0;
        axil_bus.awaddr  <= '0;
        axil_bus.awvalid <= 1'b0;
        axil_bus.wdata   <= '0;
        axil_bus.wstrb   <= '0;
        axil_bus.wvalid  <= 1'b0;
        axil_bus.bready  <= 1'b0;
        axil_bus.araddr  <= '0;
        axil_bus.arvalid <= 1'b0;
        axil_bus.rready  <= 1'b0;
        lfsr_state    = LFSR_SEED;
        random_delays = 1'b0;
        exp_status    = '0;
        exp_result    = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        for (int idx = 0; idx < REG_NUM; idx++) begin
            read_word(idx, word);
            check_word(idx, '0, word);
        end

        write_word(REG_OPA, 32'h1234_5678, 4'hf);
        wait_word(REG_OPA, 32'h1234_5678, word);
        check_word(REG_OPA, 32'h1234_5678, word);
        write_word(REG_OPA, 32'haabb_ccdd, 4'b0101);  // lanes 0 and 2 only.
        wait_word(REG_OPA, 32'h12bb_56dd, word);
        check_word(REG_OPA, 32'h12bb_56dd, word);
        write_word(REG_OPB, 32'hcafe_0042, 4'hf);
        wait_word(REG_OPB, 32'hcafe_0042, word);
        check_word(REG_OPB, 32'hcafe_0042, word);

        // the second pass repeats the table with back-pressure on B and R.
        for (int pass = 0; pass < 2; pass++) begin
            random_delays = (pass == 1);
            for (int n = 0; n < NUM_VECTORS; n++) begin
                run_vector(VECTORS[n]);
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/alu_regs_pkg.sv
hdl/axil_if.sv
hdl/axil_reg_file.sv
hdl/alu_core.sv
hdl/result_collector.sv
hdl/alu_periph_top.sv
verification/tb_alu_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the fail message.
rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_alu_periph -o tb_alu_periph \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_alu_periph > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation finished cleanly"
